//--- bomber_pkg.sv
package bomber_pkg;

  // Map geometry
  localparam int TILE_SHIFT = 3;  // 8 pixel tiles
  localparam int MAP_COLS   = 8;
  localparam int MAP_ROWS   = 5;
  localparam int MAP_DEPTH  = 40;
  localparam int MAP_ADDR_W = $clog2(MAP_DEPTH);

  typedef logic [6:0]            coord_x_t;
  typedef logic [5:0]            coord_y_t;
  typedef logic [MAP_ADDR_W-1:0] map_addr_t;  // row * MAP_COLS + col
  typedef logic [1:0]            tile_t;
  typedef logic [3:0]            count_t;
  typedef logic [3:0]            colour_t;

  // Raster limits, hsync low for columns 66 to 71
  localparam coord_x_t H_ACTIVE     = 7'd64;
  localparam coord_x_t H_TOTAL      = 7'd80;
  localparam coord_x_t H_SYNC_START = 7'd66;
  localparam coord_x_t H_SYNC_END   = 7'd72;
  localparam coord_y_t V_ACTIVE     = 6'd40;
  localparam coord_y_t V_TOTAL      = 6'd48;
  localparam coord_y_t V_SYNC_START = 6'd42;
  localparam coord_y_t V_SYNC_END   = 6'd44;

  localparam tile_t TILE_EMPTY = 2'd0;
  localparam tile_t TILE_WALL  = 2'd1;
  localparam tile_t TILE_BRICK = 2'd2;
  localparam tile_t TILE_BOMB  = 2'd3;

  // Game rules
  localparam count_t     BOMB_TIME    = 4'd3;  // Frames until the blast
  localparam count_t     BLAST_FRAMES = 4'd2;
  localparam logic [2:0] START_ROW    = 3'd1;
  localparam logic [2:0] START_COL    = 3'd1;

  typedef enum logic [2:0] {DIR_NONE, DIR_UP, DIR_DOWN, DIR_LEFT, DIR_RIGHT} dir_t;

  typedef enum logic [2:0] {IDLE, ARMED, BLAST_RD, BLAST_WR, SHOW, OVER} ctrl_state_t;

  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
  } vga_pos_t;

  typedef struct packed {
    logic [2:0] row;
    logic [2:0] col;
  } tile_pos_t;

  typedef struct packed {
    colour_t r;
    colour_t g;
    colour_t b;
  } rgb_t;

  localparam rgb_t RGB_BLACK  = '{r: 4'h0, g: 4'h0, b: 4'h0};
  localparam rgb_t RGB_RED    = '{r: 4'hF, g: 4'h0, b: 4'h0};
  localparam rgb_t RGB_GREEN  = '{r: 4'h0, g: 4'hF, b: 4'h0};
  localparam rgb_t RGB_YELLOW = '{r: 4'hF, g: 4'hF, b: 4'h0};
  localparam rgb_t RGB_GREY   = '{r: 4'h8, g: 4'h8, b: 4'h8};
  localparam rgb_t RGB_BROWN  = '{r: 4'hA, g: 4'h5, b: 4'h0};
  localparam rgb_t RGB_BLUE   = '{r: 4'h0, g: 4'h0, b: 4'hF};

  function automatic map_addr_t tile_addr(tile_pos_t p);
    return map_addr_t'(p.row) * map_addr_t'(MAP_COLS) + map_addr_t'(p.col);
  endfunction

  // Centre plus the four direct neighbours of the bomb
  function automatic logic in_cross(tile_pos_t p, tile_pos_t b);
    logic same_row;
    logic same_col;
    same_row = (p.row == b.row);
    same_col = (p.col == b.col);
    return (same_row && (same_col || p.col == b.col + 3'd1 || p.col + 3'd1 == b.col)) ||
           (same_col && (p.row == b.row + 3'd1 || p.row + 3'd1 == b.row));
  endfunction

endpackage

//--- bomber_props.sv
`timescale 1ns/10ps

module bomber_props (
  input logic               pixclk,
  input logic               i_rst,
  input logic               i_hsync,
  input bomber_pkg::count_t i_countdown,
  input logic               i_game_over,
  input logic               i_pm_wait,
  input logic               i_own_rd
);
  import bomber_pkg::*;

  logic [6:0] low_cnt;  // Cycles of the current hsync pulse

  always_ff @(posedge pixclk) begin
    if (i_hsync) low_cnt <= '0;
    else low_cnt <= low_cnt + 7'd1;
  end

  hsync_width: assert property (@(posedge pixclk) disable iff (i_rst)
    $rose(i_hsync) |-> low_cnt == 7'd6) else $error("hsync pulse width wrong");

  countdown_load: assert property (@(posedge pixclk) disable iff (i_rst)
    (i_countdown > $past(i_countdown)) |-> i_countdown == BOMB_TIME)
    else $error("countdown rose without a load");

  over_sticky: assert property (@(posedge pixclk)
    $fell(i_game_over) |-> $past(i_rst)) else $error("game over cleared without reset");

  // Read data comes back one cycle after the grant, so both readers must not collect it at once
  one_reader: assert property (@(posedge pixclk) disable iff (i_rst)
    !(i_pm_wait && $past(i_own_rd))) else $error("both map readers served in one cycle");

endmodule

bind bomber_top bomber_props u_props (
  .pixclk(pixclk), .i_rst(i_rst), .i_hsync(o_hsync), .i_countdown(o_countdown),
  .i_game_over(o_game_over), .i_pm_wait(u_player.wait_data), .i_own_rd(u_ctrl.own_rd)
);

//--- bomber_top.sv
`timescale 1ns/10ps

module bomber_top (
  input  logic               pixclk,
  input  logic               i_rst,
  input  logic               i_up,
  input  logic               i_down,
  input  logic               i_left,
  input  logic               i_right,
  input  logic               i_place_bomb,
  output bomber_pkg::rgb_t   o_pix,
  output logic               o_hsync,
  output logic               o_vsync,
  output bomber_pkg::count_t o_countdown,
  output logic               o_game_over
);
  import bomber_pkg::*;

  vga_pos_t  pos;
  logic      active;
  logic      hsync_raw;
  logic      vsync_raw;
  logic      tick;
  dir_t      dir;
  logic      pm_req;
  logic      pm_grant;
  map_addr_t pm_addr;
  map_addr_t rd_addr;
  tile_t     rd_data;
  map_addr_t ren_addr;
  tile_t     ren_data;
  logic      we;
  map_addr_t wr_addr;
  tile_t     wr_data;
  tile_pos_t player;
  tile_pos_t blast;
  logic      blast_on;

  // Only a single pressed button gives a direction
  always_comb begin
    case ({i_up, i_down, i_left, i_right})
      4'b1000: dir = DIR_UP;
      4'b0100: dir = DIR_DOWN;
      4'b0010: dir = DIR_LEFT;
      4'b0001: dir = DIR_RIGHT;
      default: dir = DIR_NONE;
    endcase
  end

  vga_timing u_timing (
    .pixclk(pixclk), .i_rst(i_rst), .o_pos(pos), .o_active(active),
    .o_hsync_raw(hsync_raw), .o_vsync_raw(vsync_raw), .o_tick(tick)
  );

  map_mem u_map (
    .pixclk(pixclk), .i_rst(i_rst),
    .i_rd_addr(rd_addr), .o_rd_data(rd_data),
    .i_ren_addr(ren_addr), .o_ren_data(ren_data),
    .i_we(we), .i_wr_addr(wr_addr), .i_wr_data(wr_data)
  );

  player_move u_player (
    .pixclk(pixclk), .i_rst(i_rst), .i_tick(tick), .i_dir(dir),
    .i_rd_grant(pm_grant), .i_rd_data(rd_data),
    .o_rd_req(pm_req), .o_rd_addr(pm_addr), .o_player(player)
  );

  game_ctrl u_ctrl (
    .pixclk(pixclk), .i_rst(i_rst), .i_tick(tick), .i_place_bomb(i_place_bomb),
    .i_player(player), .i_pm_req(pm_req), .i_pm_addr(pm_addr), .o_pm_grant(pm_grant),
    .o_rd_addr(rd_addr), .i_rd_data(rd_data),
    .o_we(we), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
    .o_blast(blast), .o_blast_on(blast_on),
    .o_countdown(o_countdown), .o_game_over(o_game_over)
  );

  pixel_render u_render (
    .pixclk(pixclk), .i_rst(i_rst), .i_pos(pos), .i_active(active),
    .i_hsync_raw(hsync_raw), .i_vsync_raw(vsync_raw),
    .o_ren_addr(ren_addr), .i_ren_data(ren_data),
    .i_player(player), .i_blast(blast), .i_blast_on(blast_on), .i_game_over(o_game_over),
    .o_pix(o_pix), .o_hsync(o_hsync), .o_vsync(o_vsync)
  );

endmodule

//--- game_ctrl.sv
`timescale 1ns/10ps

module game_ctrl (
  input  logic                  pixclk,
  input  logic                  i_rst,
  input  logic                  i_tick,
  input  logic                  i_place_bomb,
  input  bomber_pkg::tile_pos_t i_player,
  input  logic                  i_pm_req,
  input  bomber_pkg::map_addr_t i_pm_addr,
  output logic                  o_pm_grant,
  output bomber_pkg::map_addr_t o_rd_addr,
  input  bomber_pkg::tile_t     i_rd_data,
  output logic                  o_we,
  output bomber_pkg::map_addr_t o_wr_addr,
  output bomber_pkg::tile_t     o_wr_data,
  output bomber_pkg::tile_pos_t o_blast,
  output logic                  o_blast_on,
  output bomber_pkg::count_t    o_countdown,
  output logic                  o_game_over
);
  import bomber_pkg::*;

  ctrl_state_t state;
  tile_pos_t   bomb;
  tile_pos_t   cross_tile;
  logic [2:0]  idx;       // 0 centre, 1 up, 2 down, 3 left, 4 right
  count_t      show_cnt;
  logic        own_rd;    // Own read, always served first
  logic        place;

  always_comb begin
    cross_tile = bomb;
    case (idx)
      3'd1:    cross_tile.row = bomb.row - 3'd1;
      3'd2:    cross_tile.row = bomb.row + 3'd1;
      3'd3:    cross_tile.col = bomb.col - 3'd1;
      3'd4:    cross_tile.col = bomb.col + 3'd1;
      default: cross_tile = bomb;
    endcase
  end

  assign place      = (state == IDLE) && i_tick && i_place_bomb;
  assign own_rd     = (state == BLAST_RD);
  assign o_pm_grant = i_pm_req && !own_rd && (state == IDLE || state == ARMED);
  assign o_rd_addr  = own_rd ? tile_addr(cross_tile) : i_pm_addr;

  always_comb begin
    o_we      = 1'b0;
    o_wr_addr = tile_addr(cross_tile);
    o_wr_data = TILE_EMPTY;
    if (place) begin
      o_we      = 1'b1;
      o_wr_addr = tile_addr(i_player);
      o_wr_data = TILE_BOMB;
    end else if (state == BLAST_WR) begin
      o_we = (i_rd_data == TILE_BRICK) || (i_rd_data == TILE_BOMB);  // Walls survive
    end
  end

  always_ff @(posedge pixclk) begin
    if (i_rst) begin
      state       <= IDLE;
      bomb        <= '0;
      idx         <= '0;
      show_cnt    <= '0;
      o_countdown <= '0;
      o_game_over <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (place) begin
            bomb        <= i_player;
            o_countdown <= BOMB_TIME;
            state       <= ARMED;
          end
        end
        ARMED: begin
          if (i_tick) begin
            o_countdown <= o_countdown - count_t'(1);
            if (o_countdown == count_t'(1)) begin
              idx   <= '0;
              state <= BLAST_RD;
              if (in_cross(i_player, bomb)) begin
                o_game_over <= 1'b1;
              end
            end
          end
        end
        BLAST_RD: state <= BLAST_WR;  // Tile data is back next cycle
        BLAST_WR: begin
          if (idx == 3'd4) begin
            show_cnt <= '0;
            state    <= SHOW;
          end else begin
            idx   <= idx + 3'd1;
            state <= BLAST_RD;
          end
        end
        SHOW: begin
          if (i_tick) begin
            if (show_cnt == BLAST_FRAMES - count_t'(1)) begin
              state <= o_game_over ? OVER : IDLE;
            end else begin
              show_cnt <= show_cnt + count_t'(1);
            end
          end
        end
        default: state <= OVER;  // Held until reset
      endcase
    end
  end

  assign o_blast    = bomb;
  assign o_blast_on = (state == SHOW);

endmodule

//--- map_mem.sv
`timescale 1ns/10ps

module map_mem (
  input  logic                  pixclk,
  input  logic                  i_rst,
  input  bomber_pkg::map_addr_t i_rd_addr,   // Shared game logic port
  output bomber_pkg::tile_t     o_rd_data,
  input  bomber_pkg::map_addr_t i_ren_addr,  // Render port
  output bomber_pkg::tile_t     o_ren_data,
  input  logic                  i_we,
  input  bomber_pkg::map_addr_t i_wr_addr,
  input  bomber_pkg::tile_t     i_wr_data
);
  import bomber_pkg::*;

  tile_t mem [MAP_DEPTH];

  // Start map: border walls, even interior pillars, brick columns 5 and 6
  function automatic tile_t rule_tile(int row, int col);
    if (row == 0 || row == MAP_ROWS - 1 || col == 0 || col == MAP_COLS - 1) begin
      return TILE_WALL;
    end else if (row % 2 == 0 && col % 2 == 0) begin
      return TILE_WALL;
    end else if (col == 5 || col == 6) begin
      return TILE_BRICK;
    end
    return TILE_EMPTY;
  endfunction

  always_ff @(posedge pixclk) begin
    if (i_rst) begin
      for (int a = 0; a < MAP_DEPTH; a++) begin
        mem[a] <= rule_tile(a / MAP_COLS, a % MAP_COLS);
      end
    end else if (i_we) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Registered reads see the value before a same-cycle write
  always_ff @(posedge pixclk) begin
    o_rd_data  <= mem[i_rd_addr];
    o_ren_data <= mem[i_ren_addr];
  end

endmodule

//--- pixel_render.sv
`timescale 1ns/10ps

module pixel_render (
  input  logic                  pixclk,
  input  logic                  i_rst,
  input  bomber_pkg::vga_pos_t  i_pos,
  input  logic                  i_active,
  input  logic                  i_hsync_raw,
  input  logic                  i_vsync_raw,
  output bomber_pkg::map_addr_t o_ren_addr,
  input  bomber_pkg::tile_t     i_ren_data,
  input  bomber_pkg::tile_pos_t i_player,
  input  bomber_pkg::tile_pos_t i_blast,
  input  logic                  i_blast_on,
  input  logic                  i_game_over,
  output bomber_pkg::rgb_t      o_pix,
  output logic                  o_hsync,
  output logic                  o_vsync
);
  import bomber_pkg::*;

  typedef struct packed {
    tile_pos_t tile;
    logic      active;
    logic      hsync;
    logic      vsync;
    logic      blast_on;
    logic      over;
  } stage_t;

  tile_pos_t tile;
  stage_t    s1;
  rgb_t      pix_next;

  assign tile.col   = 3'(i_pos.x >> TILE_SHIFT);
  assign tile.row   = 3'(i_pos.y >> TILE_SHIFT);
  assign o_ren_addr = i_active ? tile_addr(tile) : '0;  // Stay inside the map in blanking

  // Stage 1 lines up with the tile read
  always_ff @(posedge pixclk) begin
    if (i_rst) begin
      s1       <= '0;
      s1.hsync <= 1'b1;
      s1.vsync <= 1'b1;
    end else begin
      s1.tile     <= tile;
      s1.active   <= i_active;
      s1.hsync    <= i_hsync_raw;
      s1.vsync    <= i_vsync_raw;
      s1.blast_on <= i_blast_on;
      s1.over     <= i_game_over;
    end
  end

  always_comb begin
    if (s1.active && s1.over) begin
      pix_next = RGB_RED;
    end else if (!s1.active) begin
      pix_next = RGB_BLACK;
    end else if (s1.tile == i_player) begin
      pix_next = RGB_GREEN;
    end else if (s1.blast_on && in_cross(s1.tile, i_blast)) begin
      pix_next = RGB_YELLOW;
    end else begin
      case (i_ren_data)
        TILE_WALL:  pix_next = RGB_GREY;
        TILE_BRICK: pix_next = RGB_BROWN;
        TILE_BOMB:  pix_next = RGB_BLUE;
        default:    pix_next = RGB_BLACK;
      endcase
    end
  end

  // Stage 2 output registers
  always_ff @(posedge pixclk) begin
    if (i_rst) begin
      o_pix   <= RGB_BLACK;
      o_hsync <= 1'b1;
      o_vsync <= 1'b1;
    end else begin
      o_pix   <= pix_next;
      o_hsync <= s1.hsync;
      o_vsync <= s1.vsync;
    end
  end

endmodule

//--- player_move.sv
`timescale 1ns/10ps

module player_move (
  input  logic                  pixclk,
  input  logic                  i_rst,
  input  logic                  i_tick,
  input  bomber_pkg::dir_t      i_dir,
  input  logic                  i_rd_grant,
  input  bomber_pkg::tile_t     i_rd_data,
  output logic                  o_rd_req,
  output bomber_pkg::map_addr_t o_rd_addr,
  output bomber_pkg::tile_pos_t o_player
);
  import bomber_pkg::*;

  tile_pos_t target;     // Tile the player tries to step onto
  tile_pos_t next_tile;
  logic      wait_data;  // Read granted, data arrives this cycle

  always_comb begin
    next_tile = o_player;
    case (i_dir)
      DIR_UP:    next_tile.row = o_player.row - 3'd1;
      DIR_DOWN:  next_tile.row = o_player.row + 3'd1;
      DIR_LEFT:  next_tile.col = o_player.col - 3'd1;
      DIR_RIGHT: next_tile.col = o_player.col + 3'd1;
      default:   next_tile = o_player;
    endcase
  end

  always_ff @(posedge pixclk) begin
    if (i_rst) begin
      o_player.row <= START_ROW;
      o_player.col <= START_COL;
      target       <= '0;
      o_rd_req     <= 1'b0;
      o_rd_addr    <= '0;
      wait_data    <= 1'b0;
    end else begin
      if (i_tick && i_dir != DIR_NONE && !o_rd_req && !wait_data) begin
        target    <= next_tile;
        o_rd_req  <= 1'b1;
        o_rd_addr <= tile_addr(next_tile);
      end else if (o_rd_req && i_rd_grant) begin
        o_rd_req  <= 1'b0;  // Held until the arbiter takes it
        wait_data <= 1'b1;
      end
      if (wait_data) begin
        wait_data <= 1'b0;
        if (i_rd_data == TILE_EMPTY) begin
          o_player <= target;
        end
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_bomber -f tb.f -o sim_bomber
./obj_dir/sim_bomber > sim.log 2>&1 || true
cat sim.log
if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then
  exit 1
fi
exit 0

//--- tb.f
bomber_pkg.sv
vga_timing.sv
map_mem.sv
player_move.sv
game_ctrl.sv
pixel_render.sv
bomber_top.sv
bomber_props.sv
tb_bomber.sv

//--- tb_bomber.sv
`timescale 1ns/10ps

module tb_bomber;
  import bomber_pkg::*;

  localparam int FRAME_CYCLES   = 80 * 48;
  localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES;  // About 35 frames of tests

  logic   pixclk;
  logic   i_rst;
  logic   i_up;
  logic   i_down;
  logic   i_left;
  logic   i_right;
  logic   i_place_bomb;
  rgb_t   o_pix;
  logic   o_hsync;
  logic   o_vsync;
  count_t o_countdown;
  logic   o_game_over;

  int          seed = 61;
  int          cycles = 0;
  int          model [5][8];  // Expected tile codes
  int          p_row = 1;
  int          p_col = 1;
  int          b_row = 0;
  int          b_col = 0;
  logic        blast_on = 1'b0;
  logic        over = 1'b0;
  logic [11:0] centre [5][8];  // Last sampled colour at each tile centre
  int          sx = 0;
  int          sy = 0;
  logic        prev_h = 1'b1;
  logic        prev_v = 1'b1;
  logic        synced = 1'b0;
  event        frame_done;

  bomber_top DUT (
    .pixclk(pixclk), .i_rst(i_rst), .i_up(i_up), .i_down(i_down), .i_left(i_left),
    .i_right(i_right), .i_place_bomb(i_place_bomb), .o_pix(o_pix), .o_hsync(o_hsync),
    .o_vsync(o_vsync), .o_countdown(o_countdown), .o_game_over(o_game_over)
  );

  initial begin
    pixclk = 1'b0;
    forever #50 pixclk = ~pixclk;
  end

  always @(posedge pixclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) stop_run("timeout: the tests did not finish in time");
  end

  // Pixel sampler locked to the falling sync edges
  always @(negedge pixclk) begin
    if (prev_h && !o_hsync) begin
      sx = 66;
    end else if (prev_v && !o_vsync) begin
      sx = 0;
      sy = 42;
      synced = 1'b1;
    end else begin
      sx++;
      if (sx == 80) begin
        sx = 0;
        sy = (sy == 47) ? 0 : sy + 1;
      end
    end
    prev_h = o_hsync;
    prev_v = o_vsync;
    if (synced && sx < 64 && sy < 40 && sx % 8 == 4 && sy % 8 == 4) centre[sy / 8][sx / 8] = o_pix;
    if (synced && sx == 63 && sy == 39) -> frame_done;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  task automatic build_model();
    for (int r = 0; r < 5; r++) begin
      for (int c = 0; c < 8; c++) begin
        if (r == 0 || r == 4 || c == 0 || c == 7) model[r][c] = 1;
        else if (r % 2 == 0 && c % 2 == 0) model[r][c] = 1;
        else if (c == 5 || c == 6) model[r][c] = 2;
        else model[r][c] = 0;
      end
    end
  endtask

  function automatic logic in_blast(int r, int c);
    int dr;
    int dc;
    dr = r - b_row;
    dc = c - b_col;
    return (dr == 0 && dc >= -1 && dc <= 1) || (dc == 0 && (dr == 1 || dr == -1));
  endfunction

  function automatic logic [11:0] expected_pix(int r, int c);
    if (over) return 12'hF00;
    if (r == p_row && c == p_col) return 12'h0F0;
    if (blast_on && in_blast(r, c)) return 12'hFF0;
    case (model[r][c])
      1: return 12'h888;
      2: return 12'hA50;
      3: return 12'h00F;
      default: return 12'h000;
    endcase
  endfunction

  task automatic check_frame();
    for (int r = 0; r < 5; r++) begin
      for (int c = 0; c < 8; c++) begin
        check($sformatf("o_pix tile %0d,%0d", r, c), 32'(centre[r][c]),
              32'(expected_pix(r, c)));
      end
    end
  endtask

  // Bricks and the bomb inside the cross are cleared
  task automatic apply_blast();
    for (int r = 0; r < 5; r++) begin
      for (int c = 0; c < 8; c++) begin
        if (in_blast(r, c) && model[r][c] >= 2) model[r][c] = 0;
      end
    end
  endtask

  // Holds the buttons over exactly one frame tick
  task automatic press(input logic up, input logic down, input logic left, input logic right,
                       input logic bomb);
    @(posedge pixclk);
    #1;
    {i_up, i_down, i_left, i_right, i_place_bomb} = {up, down, left, right, bomb};
    @(frame_done);
    @(posedge pixclk);
    #1;
    {i_up, i_down, i_left, i_right, i_place_bomb} = 5'b0;
  endtask

  task automatic sync_timing();
    time t0;
    time t1;
    time t2;
    @(negedge o_hsync) t0 = $time;
    @(posedge o_hsync) t1 = $time;
    @(negedge o_hsync) t2 = $time;
    check("o_hsync low cycles", 32'((t1 - t0) / 100), 6);
    check("o_hsync period", 32'((t2 - t0) / 100), 80);
    @(negedge o_vsync) t0 = $time;
    @(posedge o_vsync) t1 = $time;
    @(negedge o_vsync) t2 = $time;
    check("o_vsync low lines", 32'((t1 - t0) / 8000), 2);
    check("o_vsync period", 32'((t2 - t0) / 8000), 48);
  endtask

  task automatic initial_frame();
    int r;
    int c;
    @(frame_done);
    @(frame_done);
    check("o_pix player", 32'(centre[1][1]), 32'h0F0);
    repeat (10) begin
      r = $unsigned($random(seed)) % 5;
      c = $unsigned($random(seed)) % 8;
      check($sformatf("o_pix tile %0d,%0d", r, c), 32'(centre[r][c]),
            32'(expected_pix(r, c)));
    end
  endtask

  task automatic movement();
    press(0, 1, 0, 0, 0);
    p_row = 2;  // (2,1) is empty
    check_frame();
    press(0, 0, 0, 1, 0);  // Wall at (2,2)
    check_frame();
  endtask

  task automatic countdown();
    press(1, 0, 0, 0, 0);
    p_row = 1;
    repeat (3) begin
      press(0, 0, 0, 1, 0);
      p_col++;
    end
    check_frame();
    press(0, 0, 0, 0, 1);
    model[1][4] = 3;
    b_row = 1;
    b_col = 4;
    check("o_countdown", 32'(o_countdown), 3);
    press(0, 0, 1, 0, 0);
    p_col = 3;
    check("o_countdown", 32'(o_countdown), 2);
    check_frame();
    press(0, 0, 1, 0, 0);
    p_col = 2;
    check("o_countdown", 32'(o_countdown), 1);
    @(frame_done);
    check("o_countdown", 32'(o_countdown), 0);
    apply_blast();
    blast_on = 1'b1;
    check_frame();
    @(frame_done);
    @(frame_done);
    blast_on = 1'b0;
    check_frame();
  endtask

  task automatic blast();
    repeat (3) begin
      press(0, 0, 0, 1, 0);
      p_col++;
    end
    press(0, 0, 0, 0, 1);
    model[1][5] = 3;
    b_row = 1;
    b_col = 5;
    press(0, 0, 1, 0, 0);
    press(0, 0, 1, 0, 0);
    p_col = 3;  // Outside the cross
    @(frame_done);
    apply_blast();
    blast_on = 1'b1;
    check_frame();
    check("o_game_over", 32'(o_game_over), 0);
    @(frame_done);
    check_frame();
    @(frame_done);
    blast_on = 1'b0;
    check_frame();
    check("o_pix tile 1,6", 32'(centre[1][6]), 32'h000);
  endtask

  task automatic game_over();
    press(0, 0, 0, 0, 1);
    b_row = p_row;
    b_col = p_col;
    repeat (3) @(frame_done);
    check("o_game_over", 32'(o_game_over), 1);
    over = 1'b1;
    check_frame();
    repeat (3) @(frame_done);
    check("o_game_over", 32'(o_game_over), 1);
    check_frame();
  endtask

  initial begin
    {i_up, i_down, i_left, i_right, i_place_bomb} = 5'b0;
    i_rst = 1'b1;
    build_model();
    repeat (4) @(posedge pixclk);
    #1;
    i_rst = 1'b0;
    sync_timing();
    initial_frame();
    movement();
    countdown();
    blast();
    game_over();
    $display("all tests passed");
    $finish;
  end

endmodule

//--- vga_timing.sv
`timescale 1ns/10ps

module vga_timing (
  input  logic                 pixclk,
  input  logic                 i_rst,
  output bomber_pkg::vga_pos_t o_pos,
  output logic                 o_active,
  output logic                 o_hsync_raw,
  output logic                 o_vsync_raw,
  output logic                 o_tick
);
  import bomber_pkg::*;

  coord_x_t x_cnt;
  coord_y_t y_cnt;

  always_ff @(posedge pixclk) begin
    if (i_rst) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (x_cnt == H_TOTAL - coord_x_t'(1)) begin
      x_cnt <= '0;  // End of line
      if (y_cnt == V_TOTAL - coord_y_t'(1)) begin
        y_cnt <= '0;
      end else begin
        y_cnt <= y_cnt + coord_y_t'(1);
      end
    end else begin
      x_cnt <= x_cnt + coord_x_t'(1);
    end
  end

  // One pulse per frame, just after the origin pixel
  always_ff @(posedge pixclk) begin
    if (i_rst) begin
      o_tick <= 1'b0;
    end else begin
      o_tick <= (x_cnt == '0) && (y_cnt == '0);
    end
  end

  assign o_pos.x     = x_cnt;
  assign o_pos.y     = y_cnt;
  assign o_active    = (x_cnt < H_ACTIVE) && (y_cnt < V_ACTIVE);
  assign o_hsync_raw = !((x_cnt >= H_SYNC_START) && (x_cnt < H_SYNC_END));  // Active low
  assign o_vsync_raw = !((y_cnt >= V_SYNC_START) && (y_cnt < V_SYNC_END));

endmodule
